/* all.f */
verilog/cpu_pkg.sv
verilog/program_loader.sv
verilog/fetch_stage.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/cpu_top.sv
sim/tb_cpu.sv

/* Makefile */
SIM      = verilator
TOP      = tb_cpu
FILELIST = all.f
FLAGS    = --binary --timing --assert
LINT     = --lint-only --timing
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "TESTBENCH PASSED" $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)

/* sim/tb_cpu.sv */
`timescale 1ns/1ns

module tb_cpu;
    import cpu_pkg::*;

    localparam int CLK_PERIOD_NS   = 100;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 200;
    localparam int WATCHDOG_NS     = NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD_NS + 20000;

    localparam logic [2:0] F3_ADD   = 3'b000;
    localparam logic [2:0] F3_XOR   = 3'b100;
    localparam logic [2:0] F3_OR    = 3'b110;
    localparam logic [2:0] F3_AND   = 3'b111;
    localparam logic [6:0] F7_BASE  = 7'b0000000;
    localparam logic [6:0] F7_SUB   = 7'b0100000;
    localparam logic [6:0] OPC_LUI  = 7'b0110111;   // not implemented here
    localparam logic [6:0] OPC_LOAD = 7'b0000011;   // loads dropped

    logic       clk_i = 1'b0;
    logic       reset;
    logic [7:0] byte_i;
    logic       byte_valid_i;
    reg_addr_t  address_i;
    logic [1:0] vout_addr_i;
    logic [7:0] value_o;
    logic       run_o;

    logic [15:0] lfsr_q;
    word_t       model_regs [32];
    word_t       prog_q [$];
    string       test_name;
    int          value_errors;
    int          protocol_errors;

    cpu_top i_dut (
        .clk_i        (clk_i),
        .reset        (reset),
        .byte_i       (byte_i),
        .byte_valid_i (byte_valid_i),
        .address_i    (address_i),
        .vout_addr_i  (vout_addr_i),
        .value_o      (value_o),
        .run_o        (run_o)
    );

    always #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    function automatic logic [11:0] rand_imm();
        return 12'(rand_bits(12));
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPCODE_OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd);
        return {imm, rs1, f3, rd, OPCODE_OP_IMM};
    endfunction

    // reference model applies one instruction at a time in program order
    task automatic model_exec(input word_t w);
        logic [6:0] opc;
        logic [2:0] f3;
        word_t      a;
        word_t      b;
        word_t      r;
        logic       ok;
        opc = w[6:0];
        f3  = w[14:12];
        a   = model_regs[w[19:15]];
        b   = (opc == OPCODE_OP_IMM) ? {{20{w[31]}}, w[31:20]} : model_regs[w[24:20]];
        ok  = (opc == OPCODE_OP) || (opc == OPCODE_OP_IMM);
        r   = '0;
        case (f3)
            F3_ADD:  r = (opc == OPCODE_OP && w[31:25] == F7_SUB) ? a - b : a + b;
            F3_XOR:  r = a ^ b;
            F3_OR:   r = a | b;
            F3_AND:  r = a & b;
            default: ok = 1'b0;
        endcase
        if (ok && w[11:7] != 5'd0) model_regs[w[11:7]] = r;
    endtask

    task automatic emit(input word_t w);
        prog_q.push_back(w);
        model_exec(w);
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        prog_q.delete();
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        reset        = 1'b1;
        byte_valid_i = 1'b0;
        repeat (4) @(negedge clk_i);
        reset        = 1'b0;
    endtask

    task automatic expect_not_running(input string where);
        if (run_o !== 1'b0) begin
            protocol_errors++;
            $display("%s: run_o went high %s", test_name, where);
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        byte_i       = b;
        byte_valid_i = 1'b1;
        @(negedge clk_i);
        byte_valid_i = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        byte_valid_i = 1'b0;
        repeat (n) begin
            byte_i = 8'(rand_bits(8));        // junk that is never qualified
            @(negedge clk_i);
        end
    endtask

    // noisy adds junk before the start marker and gaps inside words
    task automatic load_program(input logic noisy);
        word_t      cur;
        logic [7:0] jb;
        if (noisy) begin
            send_byte(LOAD_END);              // end marker while idle
            repeat (6) begin
                jb = 8'(rand_bits(8));
                expect_not_running("before the start marker");
                send_byte((jb == LOAD_START) ? 8'h00 : jb);
            end
        end
        send_byte(LOAD_START);
        for (int w = 0; w < prog_q.size(); w++) begin
            cur = prog_q[w];
            for (int lane = 0; lane < 4; lane++) begin
                if (noisy && rand_bits(2) == 32'd0) idle_cycles(1 + int'(rand_bits(1)));
                expect_not_running("while loading");
                send_byte(cur[lane*8 +: 8]);
            end
        end
        expect_not_running("before the end marker");
        send_byte(LOAD_END);
        if (run_o !== 1'b1) begin
            protocol_errors++;
            $display("%s: run_o did not rise one cycle after the end marker", test_name);
        end
    endtask

    task automatic read_reg(input reg_addr_t r, output word_t v);
        for (int lane = 0; lane < 4; lane++) begin
            address_i   = r;
            vout_addr_i = 2'(lane);
            @(negedge clk_i);                 // settled since the last posedge
            v[lane*8 +: 8] = value_o;
        end
    endtask

    task automatic check_regs(input int first, input int last);
        word_t got;
        for (int i = first; i <= last; i++) begin
            read_reg(reg_addr_t'(i), got);
            if (got !== model_regs[i]) begin
                value_errors++;
                $display("[FAIL] %s: x%0d expected 0x%08h actual 0x%08h",
                         test_name, i, model_regs[i], got);
            end
        end
    endtask

    task automatic run_and_check(input int first, input int last);
        repeat (prog_q.size() + 8) @(negedge clk_i);
        check_regs(first, last);
    endtask

    task automatic test_alu_ops();
        start_test("alu_ops");
        emit(enc_i(rand_imm(), 5'd0, F3_ADD, 5'd1));
        emit(enc_i(rand_imm() | 12'h800, 5'd0, F3_ADD, 5'd2));   // negative
        emit(enc_i(rand_imm(), 5'd1, F3_XOR, 5'd3));
        emit(enc_i(rand_imm(), 5'd2, F3_OR, 5'd4));
        emit(enc_i(rand_imm(), 5'd3, F3_AND, 5'd5));
        emit(enc_r(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd6));
        emit(enc_r(F7_SUB, 5'd4, 5'd3, F3_ADD, 5'd7));
        emit(enc_r(F7_BASE, 5'd5, 5'd4, F3_AND, 5'd8));
        emit(enc_r(F7_BASE, 5'd5, 5'd1, F3_OR, 5'd9));
        emit(enc_r(F7_BASE, 5'd3, 5'd2, F3_XOR, 5'd10));
        load_program(1'b0);
        run_and_check(0, 10);
    endtask

    task automatic test_forwarding();
        start_test("forwarding");
        emit(enc_i(rand_imm(), 5'd0, F3_ADD, 5'd1));
        emit(enc_r(F7_BASE, 5'd1, 5'd1, F3_ADD, 5'd2));          // distance 1
        emit(enc_r(F7_SUB, 5'd1, 5'd2, F3_ADD, 5'd3));           // 1 and 2
        emit(enc_r(F7_BASE, 5'd1, 5'd3, F3_XOR, 5'd4));          // 1 and 3
        emit(enc_r(F7_BASE, 5'd4, 5'd2, F3_OR, 5'd5));
        emit(enc_i(rand_imm(), 5'd5, F3_ADD, 5'd5));
        emit(enc_i(rand_imm(), 5'd0, F3_ADD, 5'd6));
        emit(enc_i(rand_imm() | 12'h800, 5'd0, F3_ADD, 5'd6));
        emit(enc_r(F7_BASE, 5'd5, 5'd6, F3_ADD, 5'd7));          // younger x6 wins
        emit(enc_r(F7_BASE, 5'd3, 5'd7, F3_AND, 5'd8));
        load_program(1'b0);
        run_and_check(0, 8);
    endtask

    task automatic test_zero_and_illegal();
        word_t w;
        start_test("zero_and_illegal");
        emit(enc_i(rand_imm() | 12'h001, 5'd0, F3_ADD, 5'd1));
        emit(enc_i(rand_imm() | 12'h002, 5'd0, F3_ADD, 5'd2));
        emit(enc_i(rand_imm() | 12'h004, 5'd1, F3_ADD, 5'd0));   // x0 target
        emit(enc_r(F7_BASE, 5'd2, 5'd1, F3_OR, 5'd0));
        emit(enc_r(F7_BASE, 5'd1, 5'd0, F3_ADD, 5'd3));          // x0 at distance 1
        emit(enc_r(F7_BASE, 5'd0, 5'd2, F3_XOR, 5'd4));          // x0 at distance 2
        w = enc_r(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd2);
        emit({w[31:7], OPC_LUI});
        w = enc_i(rand_imm(), 5'd2, F3_ADD, 5'd1);
        emit({w[31:7], OPC_LOAD});
        emit(enc_r(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd5));          // right after both
        load_program(1'b0);
        run_and_check(0, 5);
    endtask

    task automatic test_loading_protocol();
        start_test("loading_protocol");
        emit(enc_i(rand_imm(), 5'd0, F3_ADD, 5'd1));
        emit(enc_i(rand_imm(), 5'd1, F3_AND, 5'd31));            // byte 1 is 8'hFF
        emit(enc_r(F7_BASE, 5'd31, 5'd1, F3_ADD, 5'd2));
        emit(enc_i(rand_imm() | 12'h800, 5'd2, F3_XOR, 5'd3));
        emit(enc_r(F7_SUB, 5'd3, 5'd31, F3_ADD, 5'd4));
        load_program(1'b1);
        run_and_check(0, 4);
        check_regs(31, 31);
    endtask

    // stale words from longer programs sit past the end of this one
    task automatic test_program_end();
        start_test("program_end");
        emit(enc_i(rand_imm(), 5'd0, F3_ADD, 5'd1));
        emit(enc_i(rand_imm(), 5'd1, F3_ADD, 5'd2));
        emit(enc_r(F7_BASE, 5'd2, 5'd1, F3_XOR, 5'd3));
        load_program(1'b0);
        run_and_check(0, 10);
        repeat (20) @(negedge clk_i);
        check_regs(0, 10);
    endtask

    initial begin
        lfsr_q          = 16'd12485;
        reset           = 1'b1;
        byte_i          = 8'h00;
        byte_valid_i    = 1'b0;
        address_i       = '0;
        vout_addr_i     = 2'd0;
        value_errors    = 0;
        protocol_errors = 0;
        test_alu_ops();
        test_forwarding();
        test_zero_and_illegal();
        test_loading_protocol();
        test_program_end();
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* verilog/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top (
    input  logic                clk_i,
    input  logic                reset,
    input  logic [7:0]          byte_i,
    input  logic                byte_valid_i,
    input  cpu_pkg::reg_addr_t  address_i,
    input  logic [1:0]          vout_addr_i,
    output logic [7:0]          value_o,
    output logic                run_o
);
    import cpu_pkg::*;

    logic                run;
    logic [IMEM_AW:0]    prog_len;
    logic [IMEM_AW-1:0]  fetch_addr;
    word_t               instr;
    if_id_t              if_id;
    id_ex_t              id_ex;
    ex_wb_t              ex_wb;
    word_t               dbg_data;

    program_loader i_program_loader (
        .clk_i        (clk_i),
        .reset        (reset),
        .byte_i       (byte_i),
        .byte_valid_i (byte_valid_i),
        .fetch_addr_i (fetch_addr),
        .instr_o      (instr),
        .prog_len_o   (prog_len),
        .run_o        (run)
    );

    fetch_stage i_fetch_stage (
        .clk_i        (clk_i),
        .reset        (reset),
        .run_i        (run),
        .prog_len_i   (prog_len),
        .instr_i      (instr),
        .fetch_addr_o (fetch_addr),
        .if_id_o      (if_id)
    );

    decode_stage i_decode_stage (
        .clk_i      (clk_i),
        .reset      (reset),
        .if_id_i    (if_id),
        .wb_i       (ex_wb),                 // write-back port of the regfile
        .dbg_addr_i (address_i),
        .dbg_data_o (dbg_data),
        .id_ex_o    (id_ex)
    );

    execute_stage i_execute_stage (
        .clk_i   (clk_i),
        .reset   (reset),
        .id_ex_i (id_ex),
        .ex_wb_o (ex_wb)
    );

    assign value_o = dbg_data[{vout_addr_i, 3'b000} +: 8]; // lane 0 is the lsb
    assign run_o   = run;

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
    input  logic              clk_i,
    input  logic              reset,
    input  cpu_pkg::id_ex_t   id_ex_i,
    output cpu_pkg::ex_wb_t   ex_wb_o
);
    import cpu_pkg::*;

    ex_wb_t  ex_wb_q;
    ex_wb_t  ex_wb_d;
    logic    fwd_valid;
    logic    fwd_a;
    logic    fwd_b;
    word_t   op_a;
    word_t   rs2_val;
    word_t   op_b;
    word_t   result;

    // forward only real writes, x0 never
    assign fwd_valid = ex_wb_q.reg_write && ex_wb_q.rd != '0;
    assign fwd_a     = fwd_valid && ex_wb_q.rd == id_ex_i.rs1;
    assign fwd_b     = fwd_valid && ex_wb_q.rd == id_ex_i.rs2;

    assign op_a    = fwd_a ? ex_wb_q.result : id_ex_i.rs1_data;
    assign rs2_val = fwd_b ? ex_wb_q.result : id_ex_i.rs2_data;
    assign op_b    = id_ex_i.use_imm ? id_ex_i.imm : rs2_val;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            default: result = '0;
        endcase
    end

    always_comb begin
        ex_wb_d.result    = result;
        ex_wb_d.rd        = id_ex_i.rd;
        ex_wb_d.reg_write = id_ex_i.reg_write;
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            ex_wb_q <= '0;
        end else begin
            ex_wb_q <= ex_wb_d;
        end
    end

    assign ex_wb_o = ex_wb_q;

    // decode must never hand over an encoding outside the enum
    a_alu_op_legal: assert property (@(posedge clk_i) disable iff (reset)
        id_ex_i.alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR})
        else $error("illegal alu_op %0d", id_ex_i.alu_op);

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
    input  logic                clk_i,
    input  logic                reset,
    input  cpu_pkg::if_id_t     if_id_i,
    input  cpu_pkg::ex_wb_t     wb_i,
    input  cpu_pkg::reg_addr_t  dbg_addr_i,
    output cpu_pkg::word_t      dbg_data_o,
    output cpu_pkg::id_ex_t     id_ex_o
);
    import cpu_pkg::*;

    instr_t   instr;
    logic     is_op;
    logic     is_op_imm;
    logic     funct_ok;
    alu_op_t  alu_op;
    word_t    rs1_data;
    word_t    rs2_data;
    id_ex_t   id_ex_d;
    id_ex_t   id_ex_q;

    assign instr     = if_id_i.instr;
    assign is_op     = instr.r.opcode == OPCODE_OP;
    assign is_op_imm = instr.i.opcode == OPCODE_OP_IMM;

    // funct3 sits at the same bits in both layouts
    always_comb begin
        funct_ok = 1'b1;
        alu_op   = ALU_ADD;
        case (instr.r.funct3)
            3'b000:  alu_op = (is_op && instr.r.funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b100:  alu_op = ALU_XOR;
            3'b110:  alu_op = ALU_OR;
            3'b111:  alu_op = ALU_AND;
            default: funct_ok = 1'b0;               // shifts, compares not kept
        endcase
    end

    register_file i_register_file (
        .clk_i      (clk_i),
        .reset      (reset),
        .rs1_i      (instr.r.rs1),
        .rs2_i      (instr.r.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (wb_i),
        .dbg_addr_i (dbg_addr_i),
        .dbg_data_o (dbg_data_o)
    );

    always_comb begin
        id_ex_d.rs1_data  = rs1_data;
        id_ex_d.rs2_data  = rs2_data;
        id_ex_d.rs1       = instr.r.rs1;
        id_ex_d.rs2       = instr.r.rs2;
        id_ex_d.imm       = {{(XLEN-12){instr.i.imm[11]}}, instr.i.imm};
        id_ex_d.use_imm   = is_op_imm;
        id_ex_d.alu_op    = alu_op;
        id_ex_d.rd        = instr.r.rd;
        id_ex_d.reg_write = (is_op || is_op_imm) && funct_ok; // unknown opcode is a bubble
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

/* verilog/register_file.sv */
`timescale 1ns/1ns

module register_file (
    input  logic                clk_i,
    input  logic                reset,
    input  cpu_pkg::reg_addr_t  rs1_i,
    input  cpu_pkg::reg_addr_t  rs2_i,
    output cpu_pkg::word_t      rs1_data_o,
    output cpu_pkg::word_t      rs2_data_o,
    input  cpu_pkg::ex_wb_t     wb_i,
    input  cpu_pkg::reg_addr_t  dbg_addr_i,
    output cpu_pkg::word_t      dbg_data_o
);
    import cpu_pkg::*;

    word_t  regs_q [2**REG_AW];
    logic   wr_en;
    logic   hit_rs1;
    logic   hit_rs2;

    assign wr_en   = wb_i.reg_write && wb_i.rd != '0;    // x0 never written
    assign hit_rs1 = wr_en && wb_i.rd == rs1_i;
    assign hit_rs2 = wr_en && wb_i.rd == rs2_i;

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_AW; i++) regs_q[i] <= '0;
        end else if (wr_en) begin
            regs_q[wb_i.rd] <= wb_i.result;
        end
    end

    // write-through covers the distance-2 case
    assign rs1_data_o = hit_rs1 ? wb_i.result : regs_q[rs1_i];
    assign rs2_data_o = hit_rs2 ? wb_i.result : regs_q[rs2_i];
    assign dbg_data_o = regs_q[dbg_addr_i];

    a_x0_zero: assert property (@(posedge clk_i) disable iff (reset)
        (rs1_i != '0 || rs1_data_o == '0) && (rs2_i != '0 || rs2_data_o == '0) &&
        (dbg_addr_i != '0 || dbg_data_o == '0))
        else $error("x0 read back nonzero");

endmodule

/* verilog/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage (
    input  logic                          clk_i,
    input  logic                          reset,
    input  logic                          run_i,
    input  logic [cpu_pkg::IMEM_AW:0]     prog_len_i,
    input  cpu_pkg::word_t                instr_i,
    output logic [cpu_pkg::IMEM_AW-1:0]   fetch_addr_o,
    output cpu_pkg::if_id_t               if_id_o
);
    import cpu_pkg::*;

    word_t            pc_q;
    logic [XLEN-3:0]  pc_word;
    logic             in_prog;
    word_t            fetched;
    if_id_t           if_id_q;

    assign pc_word      = pc_q[XLEN-1:2];
    assign in_prog      = run_i && pc_word < (XLEN-2)'(prog_len_i);
    assign fetched      = in_prog ? instr_i : NOP_INSTR; // past the end only nops
    assign fetch_addr_o = pc_q[IMEM_AW+1:2];

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            pc_q          <= '0;
            if_id_q.instr <= NOP_INSTR;
            if_id_q.pc    <= '0;
        end else if (run_i) begin
            if_id_q.instr <= fetched;
            if_id_q.pc    <= pc_q;
            if (in_prog) pc_q <= pc_q + 32'd4;      // holds at program end
        end
    end

    assign if_id_o = if_id_q;

endmodule

/* verilog/program_loader.sv */
`timescale 1ns/1ns

module program_loader (
    input  logic                          clk_i,
    input  logic                          reset,
    input  logic [7:0]                    byte_i,
    input  logic                          byte_valid_i,
    input  logic [cpu_pkg::IMEM_AW-1:0]   fetch_addr_i,
    output cpu_pkg::word_t                instr_o,
    output logic [cpu_pkg::IMEM_AW:0]     prog_len_o,
    output logic                          run_o
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_RUN
    } state_t;

    state_t             state_q;
    logic [1:0]         lane_q;                      // next byte lane
    logic [IMEM_AW:0]   prog_len_q;
    word_t              shift_q;
    word_t              mem [IMEM_DEPTH];
    word_t              new_word;
    logic               end_seen;
    logic               byte_is_data;
    logic               wr_en;

    assign end_seen     = byte_valid_i && lane_q == 2'd0 && byte_i == LOAD_END;
    assign byte_is_data = byte_valid_i && state_q == S_LOAD && !end_seen;
    assign new_word     = {byte_i, shift_q[XLEN-1:8]}; // lsb arrives first
    assign wr_en        = byte_is_data && lane_q == 2'd3 && !prog_len_q[IMEM_AW]; // msb = full

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            state_q    <= S_IDLE;
            lane_q     <= 2'd0;
            prog_len_q <= '0;
        end else begin
            case (state_q)
                S_IDLE:  if (byte_valid_i && byte_i == LOAD_START) state_q <= S_LOAD;
                S_LOAD:  if (end_seen) state_q <= S_RUN;
                default: state_q <= S_RUN;                   // stays until reset
            endcase
            if (byte_is_data) lane_q <= lane_q + 2'd1;
            if (wr_en) prog_len_q <= prog_len_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (byte_is_data) shift_q <= new_word;
        if (wr_en) mem[prog_len_q[IMEM_AW-1:0]] <= new_word;
    end

    assign instr_o    = mem[fetch_addr_i];              // async read for fetch
    assign prog_len_o = prog_len_q;
    assign run_o      = state_q == S_RUN;

    // program is frozen once execution starts
    a_store_frozen: assert property (@(posedge clk_i) disable iff (reset)
        run_o |=> run_o && $stable(prog_len_o))
        else $error("instruction store changed while running");

endmodule

/* verilog/cpu_pkg.sv */
package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_AW     = 5;
    localparam int IMEM_AW    = 6;
    localparam int IMEM_DEPTH = 1 << IMEM_AW;        // instruction words

    localparam logic [6:0] OPCODE_OP     = 7'b0110011; // r-type alu
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011; // i-type alu

    localparam logic [7:0] LOAD_START = 8'hFE;
    localparam logic [7:0] LOAD_END   = 8'hFF;

    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fields_t;

    // same word, two field layouts
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

    typedef struct packed {
        instr_t instr;
        word_t  pc;
    } if_id_t;

    typedef struct packed {
        word_t     rs1_data;
        word_t     rs2_data;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;        // already sign-extended
        logic      use_imm;
        alu_op_t   alu_op;
        reg_addr_t rd;
        logic      reg_write;
    } id_ex_t;

    typedef struct packed {
        word_t     result;
        reg_addr_t rd;
        logic      reg_write;
    } ex_wb_t;

endpackage
